//--- source/owt_params.svh
// widths, field lengths and line timing of the one-wire transmitter
// fixed patterns and the watchdog read address
`ifndef OWT_PARAMS_SVH
`define OWT_PARAMS_SVH

// register bus
`define REG_AW           7
`define REG_DW           8

// frame fields
`define OWT_SYNC_BITS    4
`define OWT_TAIL_BITS    4
`define OWT_TAIL_PATTERN 4'b1100
`define OWT_CRC_BITS     8
`define OWT_CRC_POLY     8'h07

// clocks per line slot
`define OWT_SLOT_CYC     12

// watchdog adc read target
`define OWT_ADC_ADDR     7'h3A

`endif

//--- source/owt_pkg.sv
// frame state and opcode enums
// command and data types of the one-wire frame
`include "owt_params.svh"

package owt_pkg;

    typedef enum logic [2:0] {
        IDLE,
        SYNC_HEAD,
        SYNC_TAIL,
        CMD,
        DATA,
        CRC,
        END_TAIL
    } owt_state_e;

    typedef enum logic {
        OP_RD = 1'b0,
        OP_WR = 1'b1
    } owt_op_e;

    // op bit sits above the address
    typedef struct packed {
        owt_op_e                op;
        logic [`REG_AW-1:0]     addr;
    } owt_cmd_t;

    typedef logic [`REG_DW-1:0] owt_data_t;

endpackage

//--- source/owt_req_arbiter.sv
// request arbiter for spi strobes and the watchdog adc request
// holds one pending spi request, grants frames, tracks busy
`timescale 1ns/1ps
`include "owt_params.svh"

module owt_req_arbiter import owt_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_spi_owt_wen,
    input  logic                i_spi_owt_ren,
    input  logic [`REG_AW-1:0]  i_spi_owt_addr,
    input  logic [`REG_DW-1:0]  i_spi_owt_wdata,
    input  logic                i_wdg_owt_adc_req,
    input  logic                i_frame_done,
    output logic                o_frame_start,
    output owt_cmd_t            o_frame_cmd,
    output owt_data_t           o_frame_data,
    output logic                o_owt_wdg_adc_ack,
    output logic                o_owt_busy
);

    logic               spi_pend;
    owt_op_e            spi_op;
    logic [`REG_AW-1:0] spi_addr;
    owt_data_t          spi_data;
    logic               spi_grant;
    logic               wdg_grant;

    // ==================================================
    // pending spi request
    // ==================================================
    // newest strobe wins, even in the cycle it is granted
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            spi_pend <= 1'b0;
        end else if (i_spi_owt_wen || i_spi_owt_ren) begin
            spi_pend <= 1'b1;
        end else if (spi_grant) begin
            spi_pend <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_spi_owt_wen || i_spi_owt_ren) begin
            spi_op   <= i_spi_owt_wen ? OP_WR : OP_RD;
            spi_addr <= i_spi_owt_addr;
            // read frames carry a zero data field
            spi_data <= i_spi_owt_wen ? i_spi_owt_wdata : '0;
        end
    end

    // ==================================================
    // grant
    // ==================================================
    assign spi_grant     = !o_owt_busy && spi_pend;
    assign wdg_grant     = !o_owt_busy && !spi_pend && i_wdg_owt_adc_req;
    assign o_frame_start = spi_grant || wdg_grant;

    always_comb begin
        if (spi_grant) begin
            o_frame_cmd.op   = spi_op;
            o_frame_cmd.addr = spi_addr;
            o_frame_data     = spi_data;
        end else begin
            o_frame_cmd.op   = OP_RD;
            o_frame_cmd.addr = `OWT_ADC_ADDR;
            o_frame_data     = '0;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_owt_busy        <= 1'b0;
            o_owt_wdg_adc_ack <= 1'b0;
        end else begin
            o_owt_wdg_adc_ack <= wdg_grant;
            if (i_frame_done) begin
                o_owt_busy <= 1'b0;
            end else if (o_frame_start) begin
                o_owt_busy <= 1'b1;
            end
        end
    end

endmodule

//--- source/owt_bit_timer.sv
// slot timer, counts clocks inside one line slot
`timescale 1ns/1ps
`include "owt_params.svh"

module owt_bit_timer (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_slot_run,
    output logic o_slot_end
);

    localparam int CNT_W = $clog2(`OWT_SLOT_CYC);

    logic [CNT_W-1:0] slot_cnt;

    // wraps at the slot end, held at zero while idle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            slot_cnt <= '0;
        end else if (!i_slot_run || o_slot_end) begin
            slot_cnt <= '0;
        end else begin
            slot_cnt <= slot_cnt + 1'b1;
        end
    end

    assign o_slot_end = i_slot_run && (slot_cnt == CNT_W'(`OWT_SLOT_CYC - 1));

endmodule

//--- source/owt_crc8.sv
// serial crc-8, msb first, zero start, no reflection
`timescale 1ns/1ps
`include "owt_params.svh"

module owt_crc8 (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_crc_clear,
    input  logic                     i_crc_en,
    input  logic                     i_crc_bit,
    output logic [`OWT_CRC_BITS-1:0] o_crc
);

    logic fb;

    assign fb = o_crc[`OWT_CRC_BITS-1] ^ i_crc_bit;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_crc <= '0;
        end else if (i_crc_clear) begin
            o_crc <= '0;
        end else if (i_crc_en) begin
            // shift left, fold in the polynomial on feedback
            o_crc <= {o_crc[`OWT_CRC_BITS-2:0], 1'b0} ^
                     ({`OWT_CRC_BITS{fb}} & `OWT_CRC_POLY);
        end
    end

endmodule

//--- source/owt_frame_fsm.sv
// frame sequencer with bit counter and field mux
// manchester coder and registered line output
`timescale 1ns/1ps
`include "owt_params.svh"

module owt_frame_fsm import owt_pkg::*; (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_frame_start,
    input  owt_cmd_t                 i_frame_cmd,
    input  owt_data_t                i_frame_data,
    input  logic                     i_slot_end,
    input  logic [`OWT_CRC_BITS-1:0] i_crc,
    output logic                     o_slot_run,
    output logic                     o_crc_clear,
    output logic                     o_crc_en,
    output logic                     o_crc_bit,
    output logic                     o_frame_done,
    output logic                     o_owt_tx
);

    localparam int CMD_BITS  = $bits(owt_cmd_t);
    localparam int DATA_BITS = $bits(owt_data_t);
    localparam int CNT_W     = 3;

    localparam logic [`OWT_TAIL_BITS-1:0] TAIL_PAT = `OWT_TAIL_PATTERN;

    owt_state_e           state;
    logic [CNT_W-1:0]     bit_cnt;
    logic [CNT_W-1:0]     bit_max;
    logic                 phase;
    logic [CMD_BITS-1:0]  cmd_q;
    owt_data_t            data_q;
    logic                 field_bit;
    logic                 manch;
    logic                 bit_end;
    logic                 last_bit;
    logic                 tx_next;

    // ==================================================
    // field mux
    // ==================================================
    always_comb begin
        field_bit = 1'b0;
        bit_max   = '0;
        case (state)
            SYNC_HEAD: begin
                bit_max = CNT_W'(`OWT_SYNC_BITS - 1);
            end
            SYNC_TAIL, END_TAIL: begin
                field_bit = TAIL_PAT[`OWT_TAIL_BITS - 1 - bit_cnt];
                bit_max   = CNT_W'(`OWT_TAIL_BITS - 1);
            end
            CMD: begin
                field_bit = cmd_q[CMD_BITS - 1 - bit_cnt];
                bit_max   = CNT_W'(CMD_BITS - 1);
            end
            DATA: begin
                field_bit = data_q[DATA_BITS - 1 - bit_cnt];
                bit_max   = CNT_W'(DATA_BITS - 1);
            end
            CRC: begin
                field_bit = i_crc[`OWT_CRC_BITS - 1 - bit_cnt];
                bit_max   = CNT_W'(`OWT_CRC_BITS - 1);
            end
            default: begin
                field_bit = 1'b0;
                bit_max   = '0;
            end
        endcase
    end

    assign manch    = (state == SYNC_HEAD) || (state == CMD) ||
                      (state == DATA) || (state == CRC);
    // coded bits end after their second slot, raw bits after one
    assign bit_end  = i_slot_end && (!manch || phase);
    assign last_bit = (bit_cnt == bit_max);

    // ==================================================
    // sequencer
    // ==================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= IDLE;
            bit_cnt <= '0;
            phase   <= 1'b0;
        end else if (state == IDLE) begin
            bit_cnt <= '0;
            phase   <= 1'b0;
            if (i_frame_start) begin
                state <= SYNC_HEAD;
            end
        end else begin
            if (manch && i_slot_end) begin
                phase <= ~phase;
            end
            if (bit_end) begin
                if (last_bit) begin
                    bit_cnt <= '0;
                    case (state)
                        SYNC_HEAD: state <= SYNC_TAIL;
                        SYNC_TAIL: state <= CMD;
                        CMD:       state <= DATA;
                        DATA:      state <= CRC;
                        CRC:       state <= END_TAIL;
                        default:   state <= IDLE;
                    endcase
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // frame payload is taken once at the grant
    always_ff @(posedge i_clk) begin
        if (state == IDLE && i_frame_start) begin
            cmd_q  <= i_frame_cmd;
            data_q <= i_frame_data;
        end
    end

    assign o_slot_run   = (state != IDLE);
    assign o_frame_done = (state == END_TAIL) && bit_end && last_bit;

    // crc sees each command and data bit once
    assign o_crc_clear  = (state == IDLE) && i_frame_start;
    assign o_crc_en     = bit_end && ((state == CMD) || (state == DATA));
    assign o_crc_bit    = field_bit;

    // ==================================================
    // line coder
    // ==================================================
    // first slot inverted, second slot true
    always_comb begin
        if (state == IDLE) begin
            tx_next = 1'b0;
        end else if (manch) begin
            tx_next = phase ? field_bit : ~field_bit;
        end else begin
            tx_next = field_bit;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_owt_tx <= 1'b0;
        end else begin
            o_owt_tx <= tx_next;
        end
    end

endmodule

//--- source/owt_tx_top.sv
// one-wire transmitter top
// arbiter, frame fsm, slot timer and crc
`timescale 1ns/1ps
`include "owt_params.svh"

module owt_tx_top import owt_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_spi_owt_wen,
    input  logic                i_spi_owt_ren,
    input  logic [`REG_AW-1:0]  i_spi_owt_addr,
    input  logic [`REG_DW-1:0]  i_spi_owt_wdata,
    input  logic                i_wdg_owt_adc_req,
    output logic                o_owt_wdg_adc_ack,
    output logic                o_owt_busy,
    output logic                o_owt_tx
);

    logic                     frame_start;
    logic                     frame_done;
    owt_cmd_t                 frame_cmd;
    owt_data_t                frame_data;
    logic                     slot_run;
    logic                     slot_end;
    logic                     crc_clear;
    logic                     crc_en;
    logic                     crc_bit;
    logic [`OWT_CRC_BITS-1:0] crc;

    owt_req_arbiter u_arbiter (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_spi_owt_wen     (i_spi_owt_wen),
        .i_spi_owt_ren     (i_spi_owt_ren),
        .i_spi_owt_addr    (i_spi_owt_addr),
        .i_spi_owt_wdata   (i_spi_owt_wdata),
        .i_wdg_owt_adc_req (i_wdg_owt_adc_req),
        .i_frame_done      (frame_done),
        .o_frame_start     (frame_start),
        .o_frame_cmd       (frame_cmd),
        .o_frame_data      (frame_data),
        .o_owt_wdg_adc_ack (o_owt_wdg_adc_ack),
        .o_owt_busy        (o_owt_busy)
    );

    owt_frame_fsm u_fsm (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_frame_start (frame_start),
        .i_frame_cmd   (frame_cmd),
        .i_frame_data  (frame_data),
        .i_slot_end    (slot_end),
        .i_crc         (crc),
        .o_slot_run    (slot_run),
        .o_crc_clear   (crc_clear),
        .o_crc_en      (crc_en),
        .o_crc_bit     (crc_bit),
        .o_frame_done  (frame_done),
        .o_owt_tx      (o_owt_tx)
    );

    owt_bit_timer u_timer (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_slot_run (slot_run),
        .o_slot_end (slot_end)
    );

    owt_crc8 u_crc (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_crc_clear (crc_clear),
        .i_crc_en    (crc_en),
        .i_crc_bit   (crc_bit),
        .o_crc       (crc)
    );

endmodule

//--- bench/owt_clk_gen.sv
// testbench clock and power-on reset
`timescale 1ns/1ps

module owt_clk_gen #(
    parameter int HALF_NS    = 2,
    parameter int RST_CYCLES = 4
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(HALF_NS) o_clk = ~o_clk;
        end
    end

    // release just after an edge, like the other inputs
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule

//--- bench/owt_tx_chk.sv
// bound checks on the transmitter top
// ack pulse width, idle line level and frame length
`timescale 1ns/1ps
`include "owt_params.svh"

module owt_tx_chk (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_ack,
    input logic i_busy,
    input logic i_tx
);

    localparam int FRAME_CYC = 64 * `OWT_SLOT_CYC;

    int busy_len;

    // clocks spent busy in the current frame
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_len <= 0;
        end else if (i_busy) begin
            busy_len <= busy_len + 1;
        end else begin
            busy_len <= 0;
        end
    end

    ack_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_ack |=> !i_ack)
        else $error("watchdog ack held for more than one clock");

    line_low_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_busy |-> !i_tx)
        else $error("line high while not busy");

    busy_not_long: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_busy |-> busy_len < FRAME_CYC)
        else $error("busy longer than one frame");

    busy_full_frame: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(i_busy) |-> busy_len == FRAME_CYC)
        else $error("busy ended before a full frame");

endmodule

bind owt_tx_top owt_tx_chk u_chk (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_ack   (o_owt_wdg_adc_ack),
    .i_busy  (o_owt_busy),
    .i_tx    (o_owt_tx)
);

//--- bench/owt_tx_tb.sv
// testbench top for the one-wire transmitter
// reads frame vectors, drives spi and watchdog requests, decodes the line
`timescale 1ns/1ps
`include "owt_params.svh"

module owt_tx_tb;

    localparam int TIMEOUT    = 2000;
    localparam int VEC_FIELDS = 7;
    localparam int VEC_MAX    = 16;
    // slot offsets of the fields within a frame
    localparam int STAIL_SL   = 8;
    localparam int CMD_SL     = 12;
    localparam int DATA_SL    = 28;
    localparam int CRC_SL     = 44;
    localparam int ETAIL_SL   = 60;
    localparam int SLOTS      = 64;

    logic               clk;
    logic               rst_n;
    logic               spi_wen;
    logic               spi_ren;
    logic [`REG_AW-1:0] spi_addr;
    logic [`REG_DW-1:0] spi_wdata;
    logic               adc_req;
    logic               adc_ack;
    logic               busy;
    logic               tx;

    logic [7:0]         vec_mem [0:VEC_FIELDS*VEC_MAX-1];
    logic               slot_val [0:SLOTS-1];
    int                 errors;
    int                 test_errs;
    int                 ack_count = 0;
    bit                 timed_out;
    int                 idx;

    owt_clk_gen u_clk_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    owt_tx_top DUT (
        .i_clk             (clk),
        .i_rst_n           (rst_n),
        .i_spi_owt_wen     (spi_wen),
        .i_spi_owt_ren     (spi_ren),
        .i_spi_owt_addr    (spi_addr),
        .i_spi_owt_wdata   (spi_wdata),
        .i_wdg_owt_adc_req (adc_req),
        .o_owt_wdg_adc_ack (adc_ack),
        .o_owt_busy        (busy),
        .o_owt_tx          (tx)
    );

    always @(negedge clk) begin
        if (adc_ack) begin
            ack_count = ack_count + 1;
        end
    end

    // ==================================================
    // stimulus and waits
    // ==================================================
    task automatic drive_strobe(input logic wr, input logic [`REG_AW-1:0] addr,
                                input logic [`REG_DW-1:0] data);
        @(posedge clk);
        #1;
        spi_wen   = wr;
        spi_ren   = !wr;
        spi_addr  = addr;
        spi_wdata = data;
        @(posedge clk);
        #1;
        spi_wen = 1'b0;
        spi_ren = 1'b0;
    endtask

    task automatic wait_reset;
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (busy !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy !== level) begin
            $display("timeout: busy did not go to %0b within %0d clocks", level, TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_ack;
        int n;
        n = 0;
        @(negedge clk);
        while (adc_ack !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (adc_ack !== 1'b1) begin
            $display("timeout: the watchdog request was never acknowledged");
            timed_out = 1'b1;
        end
    endtask

    // line is low on entry, so the first high sample is the frame start
    task automatic wait_tx_rise;
        int n;
        n = 0;
        @(negedge clk);
        while (tx !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (tx !== 1'b1) begin
            $display("timeout: no frame started on the line");
            timed_out = 1'b1;
        end
    endtask

    // one sample near the centre of every slot
    task automatic capture_frame;
        repeat (`OWT_SLOT_CYC / 2 - 1) @(negedge clk);
        for (int s = 0; s < SLOTS; s++) begin
            if (s > 0) begin
                repeat (`OWT_SLOT_CYC) @(negedge clk);
            end
            slot_val[s] = tx;
        end
    endtask

    // ==================================================
    // line decode and checks
    // ==================================================
    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %02h expected %02h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    // two slots per bit, first slot inverted
    task automatic decode_coded(input int first, input int nbits, input string name,
                                output logic [7:0] value);
        value = '0;
        for (int b = 0; b < nbits; b++) begin
            assert (slot_val[first + 2*b] !== slot_val[first + 2*b + 1]) else begin
                $display("%0t: %s bit %0d has no mid-bit transition", $time, name, b);
                test_errs++;
            end
            value = {value[6:0], slot_val[first + 2*b + 1]};
        end
    endtask

    function automatic logic [7:0] raw_field(input int first);
        logic [7:0] value;
        value = '0;
        for (int b = 0; b < `OWT_TAIL_BITS; b++) begin
            value = {value[6:0], slot_val[first + b]};
        end
        return value;
    endfunction

    task automatic check_frame(input logic [7:0] exp_cmd, input logic [7:0] exp_data,
                               input logic [7:0] exp_crc);
        logic [7:0] v;
        decode_coded(0, `OWT_SYNC_BITS, "sync head", v);
        check_byte("sync head", v, 8'h00);
        check_byte("sync tail", raw_field(STAIL_SL), 8'(`OWT_TAIL_PATTERN));
        decode_coded(CMD_SL, 8, "command", v);
        check_byte("command", v, exp_cmd);
        decode_coded(DATA_SL, 8, "data", v);
        check_byte("data", v, exp_data);
        decode_coded(CRC_SL, 8, "crc", v);
        check_byte("crc", v, exp_crc);
        check_byte("end tail", raw_field(ETAIL_SL), 8'(`OWT_TAIL_PATTERN));
    endtask

    // test kinds 1 spi, 2 watchdog, 3 spi beside watchdog, 4 pending watchdog, 5 overwrite
    task automatic run_vector(input int n);
        int         base;
        int         acks_before;
        logic [7:0] kind;
        base        = n * VEC_FIELDS;
        kind        = vec_mem[base];
        acks_before = ack_count;
        wait_busy(1'b0);
        if (timed_out) return;
        if (kind == 8'h3 || kind == 8'h5) begin
            // filler frame keeps the line busy while requests pile up
            drive_strobe(1'b1, 7'h01, 8'h00);
            wait_busy(1'b1);
            if (timed_out) return;
            if (kind == 8'h3) begin
                @(posedge clk);
                #1;
                adc_req = 1'b1;
            end else begin
                drive_strobe(1'b0, 7'h7F, 8'h00);
            end
        end
        if (kind == 8'h2) begin
            @(posedge clk);
            #1;
            adc_req = 1'b1;
        end
        if (kind == 8'h1 || kind == 8'h3 || kind == 8'h5) begin
            drive_strobe(vec_mem[base+1][0], vec_mem[base+2][6:0], vec_mem[base+3]);
        end
        if (kind == 8'h3 || kind == 8'h5) begin
            wait_busy(1'b0);
            if (timed_out) return;
        end
        if (kind == 8'h2 || kind == 8'h4) begin
            wait_ack();
            if (timed_out) return;
            @(posedge clk);
            #1;
            adc_req = 1'b0;
        end
        wait_tx_rise();
        if (timed_out) return;
        capture_frame();
        check_frame(vec_mem[base+4], vec_mem[base+5], vec_mem[base+6]);
        check_byte("adc ack pulses", 8'(ack_count - acks_before),
                   (kind == 8'h2 || kind == 8'h4) ? 8'd1 : 8'd0);
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        $timeformat(-9, 0, " ns", 0);
        spi_wen   = 1'b0;
        spi_ren   = 1'b0;
        spi_addr  = '0;
        spi_wdata = '0;
        adc_req   = 1'b0;
        errors    = 0;
        timed_out = 1'b0;
        for (int i = 0; i < VEC_FIELDS*VEC_MAX; i++) begin
            vec_mem[i] = 8'hFF;
        end
        $readmemh("bench/owt_tx_vectors.txt", vec_mem);

        test_errs = 0;
        wait_reset();
        check_byte("o_owt_tx after reset", {7'b0, tx}, 8'h00);
        check_byte("o_owt_busy after reset", {7'b0, busy}, 8'h00);
        check_byte("o_owt_wdg_adc_ack after reset", {7'b0, adc_ack}, 8'h00);
        if (timed_out) begin
            test_errs++;
        end
        $display("test reset: %0d errors", test_errs);
        errors += test_errs;

        idx = 0;
        while (idx < VEC_MAX && vec_mem[idx*VEC_FIELDS] != 8'hFF && !timed_out) begin
            test_errs = 0;
            run_vector(idx);
            if (timed_out) begin
                test_errs++;
            end
            $display("test %0d kind %0d: %0d errors", idx, vec_mem[idx*VEC_FIELDS], test_errs);
            errors += test_errs;
            idx++;
        end

        $display("tests run %0d, errors %0d", idx + 1, errors);
        if (errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- bench/owt_tx_vectors.txt
// kind op addr data | expected cmd data crc, one frame per line
// kind 1 spi, 2 watchdog, 3 spi beside watchdog, 4 pending watchdog, 5 overwrite
1 1 12 a5 92 a5 b9
1 0 45 5a 45 00 1a
2 0 00 00 3a 00 7b
3 1 21 3d a1 3d be
4 0 00 00 3a 00 7b
5 1 0f 81 8f 81 fb

//--- vlog.f
+incdir+source
source/owt_pkg.sv
source/owt_req_arbiter.sv
source/owt_bit_timer.sv
source/owt_crc8.sv
source/owt_frame_fsm.sv
source/owt_tx_top.sv
bench/owt_clk_gen.sv
bench/owt_tx_chk.sv
bench/owt_tx_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
TOP       := owt_tx_tb
FILELIST  := vlog.f
OBJDIR    := obj_dir
PASS_MSG  := === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
